//--- hw/adc_acq_pkg.sv
`default_nettype none

package adc_acq_pkg;

    // number of sequencer states, one bit each in the one-hot vector
    localparam int NUM_STATES = 17;

    // bit positions in the one-hot state vector
    localparam int ST_IDLE           = 0;
    localparam int ST_WATCH_FOR_TRIG = 1;
    localparam int ST_FILL_INIT1     = 2;
    localparam int ST_FILL_INIT2     = 3;
    localparam int ST_WAVEFORM_INIT1 = 4;
    localparam int ST_WAVEFORM_INIT2 = 5;
    localparam int ST_WAVEFORM_INIT3 = 6;
    localparam int ST_RUN1           = 7;
    localparam int ST_RUN2           = 8;
    localparam int ST_RUN3           = 9;
    localparam int ST_RUN4           = 10;
    localparam int ST_WAVEFORM_TST1  = 11;
    localparam int ST_WAVEFORM_TST2  = 12;
    localparam int ST_CHECKSUM1      = 13;
    localparam int ST_CHECKSUM2      = 14;
    localparam int ST_DDR3_WAIT      = 15;
    localparam int ST_DONE           = 16;

    // synchronizer stages for enables and trigger
    localparam int ARM_SYNC_DEPTH = 4;
    // synchronizer stages for the ddr3 write-done flag
    localparam int DDR3_SYNC_DEPTH = 2;
    // extra cycles of valid delay to cover the circular buffer read latency
    localparam int BURST_VALID_DELAY = 2;

    typedef logic [NUM_STATES-1:0] state_vec_t;

    // bit 1 from enable1, bit 0 from enable0
    typedef logic [1:0] fill_type_t;

endpackage

`default_nettype wire

//--- hw/cdc_sync_chain.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_sync_chain #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire logic clk,
    input  payload_t  din,
    output payload_t  dout
);

    // shift chain into the clk domain, stage 0 is the metastable one
    (* ASYNC_REG = "TRUE" *) payload_t sync_q [0:depth-1];

    always_ff @(posedge clk) begin
        sync_q[0] <= din;
        for (int i = 1; i < depth; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    // last stage is the settled value
    assign dout = sync_q[depth-1];

    // a single flop gives no settling time
    if (depth < 2) begin : g_depth_check
        $error("cdc_sync_chain needs at least 2 stages");
    end

endmodule

`default_nettype wire

//--- hw/acq_arm_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module acq_arm_trigger
    import adc_acq_pkg::*;
(
    input  wire logic  clk,
    input  fill_type_t enable_sync,
    input  wire logic  trig_sync,
    output logic       mode_enabled,
    output logic       trig_level,
    output fill_type_t fill_type,
    output logic       trig_pulse
);

    // one stage past the synchronizer for edge detection
    logic trig_sync_d;

    always_ff @(posedge clk) begin
        // fill type comes straight from the enable pair
        fill_type <= enable_sync;
        // armed whenever either enable is set
        mode_enabled <= |enable_sync;
    end

    always_ff @(posedge clk) begin
        trig_sync_d <= trig_sync;
        // rising edge of the trigger, passed only while armed
        trig_pulse <= trig_sync & ~trig_sync_d & mode_enabled;
    end

    // level seen by the fsm to hold in DONE until the trigger drops
    assign trig_level = trig_sync;

    // one pulse per trigger edge, never a stretched pulse
    a_trig_pulse_single: assert property (
        @(posedge clk) trig_pulse |=> !trig_pulse
    );

endmodule

`default_nettype wire

//--- hw/acq_sequencer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module acq_sequencer_fsm
    import adc_acq_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  adc_acq_full_reset,
    input  wire logic  mode_enabled,
    input  wire logic  trig_level,
    input  wire logic  trig_fifo_empty,
    input  wire logic  burst_cntr_zero,
    input  wire logic  ddr3_wr_done_sync,
    output state_vec_t next_state
);

    // current state, one bit per state
    state_vec_t state_q;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state_q <= '0;
            state_q[ST_IDLE] <= 1'b1;
        end else begin
            state_q <= next_state;
        end
    end

    always_comb begin
        // all bits low, exactly one is set below
        next_state = '0;
        case (1'b1)
            // wait until armed
            state_q[ST_IDLE]: begin
                if (mode_enabled) begin
                    next_state[ST_WATCH_FOR_TRIG] = 1'b1;
                end else begin
                    next_state[ST_IDLE] = 1'b1;
                end
            end
            // wait for a trigger address in the fifo
            state_q[ST_WATCH_FOR_TRIG]: begin
                if (!trig_fifo_empty) begin
                    next_state[ST_FILL_INIT1] = 1'b1;
                end else begin
                    next_state[ST_WATCH_FOR_TRIG] = 1'b1;
                end
            end
            // fill header, two cycles
            state_q[ST_FILL_INIT1]:     next_state[ST_FILL_INIT2] = 1'b1;
            state_q[ST_FILL_INIT2]:     next_state[ST_WAVEFORM_INIT1] = 1'b1;
            // waveform header, three cycles
            state_q[ST_WAVEFORM_INIT1]: next_state[ST_WAVEFORM_INIT2] = 1'b1;
            state_q[ST_WAVEFORM_INIT2]: next_state[ST_WAVEFORM_INIT3] = 1'b1;
            state_q[ST_WAVEFORM_INIT3]: next_state[ST_RUN1] = 1'b1;
            // four-word data burst
            state_q[ST_RUN1]:           next_state[ST_RUN2] = 1'b1;
            state_q[ST_RUN2]:           next_state[ST_RUN3] = 1'b1;
            state_q[ST_RUN3]:           next_state[ST_RUN4] = 1'b1;
            // loop for another burst until the counter runs out
            state_q[ST_RUN4]: begin
                if (burst_cntr_zero) begin
                    next_state[ST_WAVEFORM_TST1] = 1'b1;
                end else begin
                    next_state[ST_RUN1] = 1'b1;
                end
            end
            // drain the buffer read pipeline
            state_q[ST_WAVEFORM_TST1]:  next_state[ST_WAVEFORM_TST2] = 1'b1;
            state_q[ST_WAVEFORM_TST2]:  next_state[ST_CHECKSUM1] = 1'b1;
            // checksum word
            state_q[ST_CHECKSUM1]:      next_state[ST_CHECKSUM2] = 1'b1;
            state_q[ST_CHECKSUM2]:      next_state[ST_DDR3_WAIT] = 1'b1;
            // ddr3 writer still flushing
            state_q[ST_DDR3_WAIT]: begin
                if (ddr3_wr_done_sync) begin
                    next_state[ST_DONE] = 1'b1;
                end else begin
                    next_state[ST_DDR3_WAIT] = 1'b1;
                end
            end
            // hold off a retrigger while the trigger level stays high
            state_q[ST_DONE]: begin
                if (mode_enabled && trig_level) begin
                    next_state[ST_DONE] = 1'b1;
                end else begin
                    next_state[ST_IDLE] = 1'b1;
                end
            end
            // recover to idle from an illegal vector
            default:                    next_state[ST_IDLE] = 1'b1;
        endcase
    end

    a_state_onehot: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset) $onehot(state_q)
    );

endmodule

`default_nettype wire

//--- hw/acq_strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module acq_strobe_gen
    import adc_acq_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  adc_acq_full_reset,
    input  state_vec_t next_state,
    input  wire logic  dummy_dat_reset_mode,
    output logic       address_cntr_en,
    output logic       dummy_dat_reset,
    output logic       adc_mux_fill_hdr_sel,
    output logic       adc_mux_wfm_hdr_sel,
    output logic       adc_mux_dat_sel,
    output logic       adc_mux_checksum_select,
    output logic       adc_mux_checksum_update,
    output logic       burst_cntr_init,
    output logic       burst_cntr_en,
    output logic       fill_cntr_en,
    output logic       adc_acq_out_valid,
    output logic       acq_enabled,
    output logic       acq_done,
    output logic       init_circ_buf_rd_addr,
    output logic       inc_circ_buf_rd_addr,
    output logic       trig_addr_rd_en,
    output logic       latch_circ_buf_dat,
    output logic       sm_idle
);

    // header and checksum writes, valid one cycle later
    logic immed_valid;
    // burst write, valid after the buffer read delay
    logic burst_start;
    logic [BURST_VALID_DELAY-1:0] burst_dly;

    // each strobe is registered on the edge that enters its state
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            address_cntr_en <= 1'b0;
            dummy_dat_reset <= 1'b0;
            adc_mux_fill_hdr_sel <= 1'b0;
            adc_mux_wfm_hdr_sel <= 1'b0;
            adc_mux_dat_sel <= 1'b0;
            adc_mux_checksum_select <= 1'b0;
            burst_cntr_init <= 1'b0;
            burst_cntr_en <= 1'b0;
            fill_cntr_en <= 1'b0;
            acq_enabled <= 1'b0;
            acq_done <= 1'b0;
            init_circ_buf_rd_addr <= 1'b0;
            inc_circ_buf_rd_addr <= 1'b0;
            trig_addr_rd_en <= 1'b0;
            latch_circ_buf_dat <= 1'b0;
            sm_idle <= 1'b0;
            immed_valid <= 1'b0;
            burst_start <= 1'b0;
        end else begin
            // low while idle or watching, so ddr3 reads may run
            acq_enabled <= !(next_state[ST_IDLE] || next_state[ST_WATCH_FOR_TRIG]);
            sm_idle <= next_state[ST_IDLE] || next_state[ST_WATCH_FOR_TRIG];
            // fill header select, then its write
            adc_mux_fill_hdr_sel <= next_state[ST_FILL_INIT1];
            // one address step per word written to the fifo
            address_cntr_en <= next_state[ST_FILL_INIT2] || next_state[ST_WAVEFORM_INIT3]
                || next_state[ST_RUN4] || next_state[ST_CHECKSUM2];
            // waveform start: dummy counter reset, buffer start, pop trigger address
            dummy_dat_reset <= next_state[ST_WAVEFORM_INIT1] && dummy_dat_reset_mode;
            init_circ_buf_rd_addr <= next_state[ST_WAVEFORM_INIT1];
            trig_addr_rd_en <= next_state[ST_WAVEFORM_INIT1];
            adc_mux_wfm_hdr_sel <= next_state[ST_WAVEFORM_INIT2];
            burst_cntr_init <= next_state[ST_WAVEFORM_INIT2];
            // read address runs one word ahead of the latch
            inc_circ_buf_rd_addr <= next_state[ST_WAVEFORM_INIT3] || next_state[ST_RUN1]
                || next_state[ST_RUN2] || next_state[ST_RUN3] || next_state[ST_RUN4];
            burst_cntr_en <= next_state[ST_RUN1];
            // data words latched through the burst and the two drain states
            latch_circ_buf_dat <= |next_state[ST_WAVEFORM_TST2:ST_RUN1];
            adc_mux_dat_sel <= |next_state[ST_WAVEFORM_TST2:ST_RUN1];
            adc_mux_checksum_select <= next_state[ST_CHECKSUM1];
            fill_cntr_en <= next_state[ST_CHECKSUM2];
            acq_done <= next_state[ST_DONE];
            immed_valid <= next_state[ST_FILL_INIT2] || next_state[ST_WAVEFORM_INIT2]
                || next_state[ST_CHECKSUM2];
            burst_start <= next_state[ST_RUN4];
        end
    end

    // valid delay for bursts, checksum updates from the first stage
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_dly <= '0;
            adc_mux_checksum_update <= 1'b0;
            adc_acq_out_valid <= 1'b0;
        end else begin
            burst_dly <= {burst_dly[BURST_VALID_DELAY-2:0], burst_start};
            adc_mux_checksum_update <= burst_dly[0];
            adc_acq_out_valid <= immed_valid | burst_dly[BURST_VALID_DELAY-1];
        end
    end

    // the output mux may only see one source at a time
    a_mux_sel_exclusive: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        $onehot0({adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel,
                  adc_mux_dat_sel, adc_mux_checksum_select})
    );

endmodule

`default_nettype wire

//--- hw/adc_acq_sm_cbuf.sv
`timescale 1ns/1ps
`default_nettype none

module adc_acq_sm_cbuf
    import adc_acq_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  adc_acq_full_reset,
    input  wire logic  acq_enable0,
    input  wire logic  acq_enable1,
    input  wire logic  acq_trig,
    input  wire logic  trig_fifo_empty,
    input  wire logic  burst_cntr_zero,
    input  wire logic  ddr3_wr_done,
    input  wire logic  dummy_dat_reset_mode,
    output fill_type_t fill_type,
    output logic       trig_pulse,
    output logic       address_cntr_en,
    output logic       dummy_dat_reset,
    output logic       adc_mux_fill_hdr_sel,
    output logic       adc_mux_wfm_hdr_sel,
    output logic       adc_mux_dat_sel,
    output logic       adc_mux_checksum_select,
    output logic       adc_mux_checksum_update,
    output logic       burst_cntr_init,
    output logic       burst_cntr_en,
    output logic       fill_cntr_en,
    output logic       adc_acq_out_valid,
    output logic       acq_enabled,
    output logic       acq_done,
    output logic       init_circ_buf_rd_addr,
    output logic       inc_circ_buf_rd_addr,
    output logic       trig_addr_rd_en,
    output logic       latch_circ_buf_dat,
    output logic       sm_idle
);

    fill_type_t enable_sync;
    logic       trig_sync;
    logic       ddr3_wr_done_sync;
    logic       mode_enabled;
    logic       trig_level;
    state_vec_t next_state;

    // enable pair travels as one payload so both bits stay aligned
    cdc_sync_chain #(.payload_t(fill_type_t), .depth(ARM_SYNC_DEPTH)) u_enable_sync (
        .clk  (clk),
        .din  ({acq_enable1, acq_enable0}),
        .dout (enable_sync)
    );

    cdc_sync_chain #(.payload_t(logic), .depth(ARM_SYNC_DEPTH)) u_trig_sync (
        .clk  (clk),
        .din  (acq_trig),
        .dout (trig_sync)
    );

    // write-done from the ddr3 writer domain
    cdc_sync_chain #(.payload_t(logic), .depth(DDR3_SYNC_DEPTH)) u_ddr3_done_sync (
        .clk  (clk),
        .din  (ddr3_wr_done),
        .dout (ddr3_wr_done_sync)
    );

    acq_arm_trigger u_arm_trigger (
        .clk          (clk),
        .enable_sync  (enable_sync),
        .trig_sync    (trig_sync),
        .mode_enabled (mode_enabled),
        .trig_level   (trig_level),
        .fill_type    (fill_type),
        .trig_pulse   (trig_pulse)
    );

    acq_sequencer_fsm u_fsm (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .mode_enabled       (mode_enabled),
        .trig_level         (trig_level),
        .trig_fifo_empty    (trig_fifo_empty),
        .burst_cntr_zero    (burst_cntr_zero),
        .ddr3_wr_done_sync  (ddr3_wr_done_sync),
        .next_state         (next_state)
    );

    // strobes decoded from next_state alone
    acq_strobe_gen u_strobe_gen (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .next_state              (next_state),
        .dummy_dat_reset_mode    (dummy_dat_reset_mode),
        .address_cntr_en         (address_cntr_en),
        .dummy_dat_reset         (dummy_dat_reset),
        .adc_mux_fill_hdr_sel    (adc_mux_fill_hdr_sel),
        .adc_mux_wfm_hdr_sel     (adc_mux_wfm_hdr_sel),
        .adc_mux_dat_sel         (adc_mux_dat_sel),
        .adc_mux_checksum_select (adc_mux_checksum_select),
        .adc_mux_checksum_update (adc_mux_checksum_update),
        .burst_cntr_init         (burst_cntr_init),
        .burst_cntr_en           (burst_cntr_en),
        .fill_cntr_en            (fill_cntr_en),
        .adc_acq_out_valid       (adc_acq_out_valid),
        .acq_enabled             (acq_enabled),
        .acq_done                (acq_done),
        .init_circ_buf_rd_addr   (init_circ_buf_rd_addr),
        .inc_circ_buf_rd_addr    (inc_circ_buf_rd_addr),
        .trig_addr_rd_en         (trig_addr_rd_en),
        .latch_circ_buf_dat      (latch_circ_buf_dat),
        .sm_idle                 (sm_idle)
    );

endmodule

`default_nettype wire

//--- tests/adc_acq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_acq_tb
    import adc_acq_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS = 8;
    localparam int NUM_EV = 12;
    // watch codes for wait_for
    localparam int W_PULSE = 0;
    localparam int W_CHECKSUM = 1;
    localparam int W_DONE = 2;
    localparam int W_IDLE = 3;

    // one row per fill attempt
    // columns: {enable1, enable0}, dummy reset mode, burst count, expected trig pulses
    logic [1:0] tbl_en    [NUM_ROWS] = '{2'b01, 2'b10, 2'b00, 2'b11, 2'b01, 2'b00, 2'b10, 2'b11};
    logic       tbl_dmode [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    int         tbl_n     [NUM_ROWS] = '{1, 3, 2, 6, 4, 1, 2, 5};
    int         tbl_pulse [NUM_ROWS] = '{1, 1, 0, 1, 1, 0, 1, 1};
    // write-done delay column, filled from the lcg
    int         tbl_delay [NUM_ROWS];

    // counted strobes, bit order of ev
    string ev_name [NUM_EV] = '{"adc_acq_out_valid", "address_cntr_en", "inc_circ_buf_rd_addr",
        "latch_circ_buf_dat", "adc_mux_dat_sel", "adc_mux_checksum_update", "fill_cntr_en",
        "burst_cntr_init", "trig_addr_rd_en", "init_circ_buf_rd_addr", "dummy_dat_reset",
        "trig_pulse"};

    logic       clk;
    logic       adc_acq_full_reset;
    logic       acq_enable0;
    logic       acq_enable1;
    logic       acq_trig;
    logic       trig_fifo_empty;
    logic       burst_cntr_zero = 1'b1;
    logic       ddr3_wr_done;
    logic       dummy_dat_reset_mode;
    fill_type_t fill_type;
    logic       trig_pulse;
    logic       address_cntr_en;
    logic       dummy_dat_reset;
    logic       adc_mux_fill_hdr_sel;
    logic       adc_mux_wfm_hdr_sel;
    logic       adc_mux_dat_sel;
    logic       adc_mux_checksum_select;
    logic       adc_mux_checksum_update;
    logic       burst_cntr_init;
    logic       burst_cntr_en;
    logic       fill_cntr_en;
    logic       adc_acq_out_valid;
    logic       acq_enabled;
    logic       acq_done;
    logic       init_circ_buf_rd_addr;
    logic       inc_circ_buf_rd_addr;
    logic       trig_addr_rd_en;
    logic       latch_circ_buf_dat;
    logic       sm_idle;

    int          errors = 0;
    int          cyc = 0;
    logic [31:0] seed = 32'ha5fabfaa;
    int          cur_n = 0;
    logic        done_raised = 1'b0;
    int          burst_left = 0;
    int          latch_seen = 0;
    int          ev_cnt [NUM_EV];
    int          ev_base [NUM_EV];
    // expected valid and checksum update, index is cycles from now
    logic [3:0]  exp_valid = '0;
    logic [2:0]  exp_update = '0;
    logic [NUM_EV-1:0] ev;

    assign ev = {trig_pulse, dummy_dat_reset, init_circ_buf_rd_addr, trig_addr_rd_en,
                 burst_cntr_init, fill_cntr_en, adc_mux_checksum_update, adc_mux_dat_sel,
                 latch_circ_buf_dat, inc_circ_buf_rd_addr, address_cntr_en, adc_acq_out_valid};

    adc_acq_sm_cbuf DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("FAIL at time %0t: %s (got %0d, expected %0d)", $time, msg, got, exp);
        end
    endtask

    // lcg step, result scaled into lo..hi
    function automatic int rand_range(input int lo, input int hi);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return lo + int'(seed[31:16]) % (hi - lo + 1);
    endfunction

    // per-fill strobe counts for a row
    function automatic int expected_count(input int idx, input int n, input logic armed,
                                          input logic dmode, input int pulses);
        if (idx == 11) return pulses;
        if (!armed) return 0;
        case (idx)
            0, 1: return n + 3;
            2: return 4 * n + 1;
            3, 4: return 4 * n + 2;
            5: return n;
            10: return dmode ? 1 : 0;
            default: return 1;
        endcase
    endfunction

    function automatic logic watch_bit(input int sel);
        case (sel)
            W_PULSE: return trig_pulse;
            W_CHECKSUM: return fill_cntr_en;
            W_DONE: return acq_done;
            default: return sm_idle;
        endcase
    endfunction

    // inputs change 10 ns after the rising edge, outputs are stable there
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic wait_for(input int sel, input int limit, input string what);
        int n;
        n = 0;
        while (!watch_bit(sel) && n < limit) begin
            step();
            n++;
        end
        if (!watch_bit(sel)) begin
            errors++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    // burst counter model, event counts and valid timing
    always begin
        step();
        if (adc_acq_full_reset) begin
            exp_valid = '0;
            exp_update = '0;
            burst_left = 0;
        end else begin
            // loads on init, counts down once per burst
            if (burst_cntr_init) burst_left = cur_n;
            if (burst_cntr_en && burst_left > 0) burst_left = burst_left - 1;
            burst_cntr_zero = (burst_left == 0);
            for (int i = 0; i < NUM_EV; i++) begin
                if (ev[i]) ev_cnt[i]++;
            end
            exp_valid = exp_valid >> 1;
            exp_update = exp_update >> 1;
            check(32'(adc_acq_out_valid), 32'(exp_valid[0]), "adc_acq_out_valid timing");
            check(32'(adc_mux_checksum_update), 32'(exp_update[0]), "checksum update timing");
            // fill header word is written the cycle after its select
            if (adc_mux_fill_hdr_sel) exp_valid[2] = 1'b1;
            // waveform header selected and written in the same cycle
            if (adc_mux_wfm_hdr_sel) exp_valid[1] = 1'b1;
            // checksum word is written the cycle after its select
            if (adc_mux_checksum_select) exp_valid[2] = 1'b1;
            if (init_circ_buf_rd_addr) latch_seen = 0;
            if (latch_circ_buf_dat) begin
                latch_seen++;
                // last word of a burst, not the drain words
                if (latch_seen % 4 == 0 && latch_seen <= 4 * cur_n) begin
                    exp_valid[3] = 1'b1;
                    exp_update[2] = 1'b1;
                end
            end
            if (acq_done) check(32'(done_raised), 1, "acq_done before ddr3_wr_done");
        end
    end

    initial begin
        int trig_cyc;
        int done_cyc;
        int fall_cyc;
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        trig_fifo_empty = 1'b1;
        ddr3_wr_done = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) tbl_delay[r] = rand_range(3, 10);
        repeat (3) @(posedge clk);
        #10;
        adc_acq_full_reset = 1'b0;
        // first edge out of reset enters idle
        step();
        check(32'(sm_idle), 1, "sm_idle after reset");
        check(32'(ev[10:0]), 0, "strobes after reset");
        check(32'({adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel, adc_mux_checksum_select,
                   burst_cntr_en, acq_done, acq_enabled}), 0, "control after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_n = tbl_n[r];
            done_raised = 1'b0;
            ev_base = ev_cnt;
            {acq_enable1, acq_enable0} = tbl_en[r];
            dummy_dat_reset_mode = tbl_dmode[r];
            // enables need four sync stages and one register
            repeat (5) step();
            check(32'(fill_type), 32'(tbl_en[r]), "fill_type");
            acq_trig = 1'b1;
            trig_cyc = cyc;
            if (tbl_pulse[r] != 0) begin
                wait_for(W_PULSE, 20, "trig_pulse");
                check(32'(cyc - trig_cyc), 5, "trig_pulse delay");
                // trigger address shows up in the fifo a little later
                repeat (rand_range(1, 4)) step();
                trig_fifo_empty = 1'b0;
                step();
                trig_fifo_empty = 1'b1;
                wait_for(W_CHECKSUM, 100, "checksum write");
                check(32'(acq_enabled), 1, "acq_enabled during fill");
                repeat (tbl_delay[r]) step();
                ddr3_wr_done = 1'b1;
                done_raised = 1'b1;
                done_cyc = cyc;
                wait_for(W_DONE, 20, "acq_done");
                check(32'(cyc - done_cyc >= 3), 1, "acq_done latency");
                // trigger still high, so the fsm holds in done
                repeat (4) step();
                check(32'(sm_idle), 0, "sm_idle while trigger held");
                acq_trig = 1'b0;
                ddr3_wr_done = 1'b0;
                fall_cyc = cyc;
                wait_for(W_IDLE, 20, "sm_idle");
                check(32'(cyc - fall_cyc), 5, "return to idle after trigger fall");
                check(32'(acq_enabled), 0, "acq_enabled after return to idle");
            end else begin
                // disarmed, trigger must pass without a pulse
                repeat (10) step();
                acq_trig = 1'b0;
                repeat (6) step();
                check(32'(acq_enabled), 0, "acq_enabled while disarmed");
            end
            for (int i = 0; i < NUM_EV; i++) begin
                check(32'(ev_cnt[i] - ev_base[i]),
                      32'(expected_count(i, tbl_n[r], tbl_en[r] != 2'b00, tbl_dmode[r],
                                         tbl_pulse[r])),
                      $sformatf("row %0d count of %s", r, ev_name[i]));
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, 200 cycles per table row plus reset
    initial begin
        #((NUM_ROWS * 200 + 10) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", NUM_ROWS * 200 + 10);
        $display("errors: %0d", errors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hw/adc_acq_pkg.sv
hw/cdc_sync_chain.sv
hw/acq_arm_trigger.sv
hw/acq_sequencer_fsm.sv
hw/acq_strobe_gen.sv
hw/adc_acq_sm_cbuf.sv
tests/adc_acq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= adc_acq_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# fails unless the pass message appears in the simulation output
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
